// File: common/i3c_ctrl_params.svh
// Width and timing constants shared by the controller RTL and its testbench; include where needed
`ifndef I3C_CTRL_PARAMS_SVH
`define I3C_CTRL_PARAMS_SVH

// Timing values and the SCL interval counter
`define I3C_TIMER_W 20

// One bus byte, shifted MSB first
`define I3C_BYTE_W 8

// Bit index counts 8 down to 1 during the data phase
`define I3C_BIT_CNT_W 4

// PP data setup/hold around SCL edges, in system clocks
`define I3C_PP_EDGE_CYC 2

`endif

// File: common/i3c_bus_pkg.sv
// Bus-level types for the controller: speed mode, system clock, command and status words
`default_nettype none
`include "i3c_ctrl_params.svh"

package i3c_bus_pkg;

  // SDR speed modes, slowest is Sdr4
  typedef enum logic [2:0] {
    Sdr0 = 3'd0,
    Sdr1 = 3'd1,
    Sdr2 = 3'd2,
    Sdr3 = 3'd3,
    Sdr4 = 3'd4
  } i3c_trans_mode_e;

  // System clock the PP table is built for
  typedef enum logic [1:0] {
    SysClk100MHz = 2'd0,
    SysClk150MHz = 2'd1,
    SysClk200MHz = 2'd2
  } sys_clk_freq_e;

  // One byte command from the host side
  typedef struct packed {
    logic                   start;     // START before the byte
    logic                   sr;        // Repeated Start before the byte
    logic                   stop;      // STOP after the 9th bit
    logic                   is_addr;   // OD timing, ACK expected
    logic                   use_tbit;  // Drive T-bit in the 9th clock
    logic [`I3C_BYTE_W-1:0] data;
  } tx_cmd_t;

  // Per-byte result, ack/nack only meaningful with done
  typedef struct packed {
    logic done;
    logic ack;
    logic nack;
  } tx_status_t;

endpackage

`default_nettype wire

// File: common/i3c_timing_pkg.sv
// SCL timing types: the OD timing set from CSRs and the interval selector used by the FSM
`default_nettype none
`include "i3c_ctrl_params.svh"

package i3c_timing_pkg;

  // Open-drain timing, all in system clock cycles
  typedef struct packed {
    logic [`I3C_TIMER_W-1:0] thigh;    // SCL high
    logic [`I3C_TIMER_W-1:0] tlow;     // SCL low
    logic [`I3C_TIMER_W-1:0] t_r;      // Rise time
    logic [`I3C_TIMER_W-1:0] t_f;      // Fall time
    logic [`I3C_TIMER_W-1:0] thd_sta;  // START hold
    logic [`I3C_TIMER_W-1:0] tsu_sta;  // START setup
    logic [`I3C_TIMER_W-1:0] tsu_sto;  // STOP setup
    logic [`I3C_TIMER_W-1:0] tsu_dat;  // Data setup
    logic [`I3C_TIMER_W-1:0] thd_dat;  // Data hold
    logic [`I3C_TIMER_W-1:0] t_buf;    // Bus free
  } od_timing_t;

  // Interval to load into the SCL counter
  typedef enum logic [3:0] {
    SetupStart = 4'd0,
    HoldStart  = 4'd1,
    SetupData  = 4'd2,
    ClockLow   = 4'd3,
    ClockPulse = 4'd4,
    HoldBit    = 4'd5,
    SetupStop  = 4'd6,
    HoldStop   = 4'd7,
    NoDelay    = 4'd8
  } tcount_sel_e;

endpackage

`default_nettype wire

// File: timing/scl_timer.sv
// SCL interval timer; picks the OD or PP interval on load and counts it down to expiry
`timescale 1ns/1ns
`default_nettype none
`include "i3c_ctrl_params.svh"

module scl_timer (
  input  wire logic                          clk_i,
  input  wire logic                          rst_ni,
  input  wire logic                          host_enable_i,  // Counter holds when low
  input  wire i3c_bus_pkg::sys_clk_freq_e    sys_clk_freq_i,
  input  wire i3c_bus_pkg::i3c_trans_mode_e  mode_i,
  input  wire i3c_timing_pkg::od_timing_t    od_timing_i,
  input  wire logic                          load_i,
  input  wire i3c_timing_pkg::tcount_sel_e   sel_i,
  input  wire logic                          od_mode_i,      // 1: OD timing, 0: PP
  output logic                               expired_o
);
  import i3c_bus_pkg::*;
  import i3c_timing_pkg::*;

  localparam logic [`I3C_TIMER_W-1:0] CntOne  = (`I3C_TIMER_W)'(1);
  localparam logic [`I3C_TIMER_W-1:0] PpEdge  = (`I3C_TIMER_W)'(`I3C_PP_EDGE_CYC);

  logic [7:0]              pp_half_tbl;  // Raw table entry
  logic [`I3C_TIMER_W-1:0] pp_half;      // H, widened
  logic [`I3C_TIMER_W-1:0] interval;     // Value taken on load
  logic [`I3C_TIMER_W-1:0] tcount_q;

  // ==========================================================================
  // PP half-period, ceil(fsys / (2 * fscl))
  // ==========================================================================
  always_comb begin
    case (sys_clk_freq_i)
      SysClk150MHz: begin
        case (mode_i)
          Sdr0:    pp_half_tbl = 8'd6;
          Sdr1:    pp_half_tbl = 8'd10;
          Sdr2:    pp_half_tbl = 8'd13;
          Sdr3:    pp_half_tbl = 8'd19;
          default: pp_half_tbl = 8'd38;  // Sdr4 and unknown
        endcase
      end
      SysClk200MHz: begin
        case (mode_i)
          Sdr0:    pp_half_tbl = 8'd8;
          Sdr1:    pp_half_tbl = 8'd13;
          Sdr2:    pp_half_tbl = 8'd17;
          Sdr3:    pp_half_tbl = 8'd25;
          default: pp_half_tbl = 8'd50;
        endcase
      end
      default: begin                     // 100 MHz row, also for unknown clocks
        case (mode_i)
          Sdr0:    pp_half_tbl = 8'd4;
          Sdr1:    pp_half_tbl = 8'd7;
          Sdr2:    pp_half_tbl = 8'd9;
          Sdr3:    pp_half_tbl = 8'd13;
          default: pp_half_tbl = 8'd25;
        endcase
      end
    endcase
  end

  assign pp_half = {{(`I3C_TIMER_W-8){1'b0}}, pp_half_tbl};

  // ==========================================================================
  // Interval select
  // ==========================================================================
  always_comb begin
    interval = CntOne;
    if (od_mode_i) begin
      case (sel_i)
        SetupStart: interval = od_timing_i.t_r + od_timing_i.tsu_sta;
        HoldStart:  interval = od_timing_i.t_f + od_timing_i.thd_sta;
        SetupData:  interval = od_timing_i.t_r + od_timing_i.tsu_dat;
        ClockLow:   interval = od_timing_i.tlow - od_timing_i.thd_dat;
        ClockPulse: interval = od_timing_i.t_r + od_timing_i.thigh;
        HoldBit:    interval = od_timing_i.t_f + od_timing_i.thd_dat;
        SetupStop:  interval = od_timing_i.t_r + od_timing_i.tsu_sto;
        HoldStop:   interval = od_timing_i.t_r + od_timing_i.t_buf - od_timing_i.tsu_sta;
        default:    interval = CntOne;  // NoDelay
      endcase
    end else begin
      case (sel_i)
        ClockLow, ClockPulse:                        interval = pp_half;  // 50% duty
        SetupStart, HoldStart, SetupStop, HoldStop:  interval = pp_half >> 1;
        SetupData, HoldBit:                          interval = PpEdge;
        default:                                     interval = CntOne;
      endcase
    end
  end

  // Counter parks at 1, a load of N gives exactly N enabled cycles
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      tcount_q <= CntOne;
    end else if (load_i) begin
      tcount_q <= interval;
    end else if (host_enable_i && (tcount_q > CntOne)) begin
      tcount_q <= tcount_q - CntOne;
    end
  end

  assign expired_o = (tcount_q == CntOne);

endmodule

`default_nettype wire

// File: design/byte_serializer.sv
// Byte serializer: bit index, TX byte register and the sampled 9th-bit ACK level
`timescale 1ns/1ns
`default_nettype none
`include "i3c_ctrl_params.svh"

module byte_serializer (
  input  wire logic                   clk_i,
  input  wire logic                   rst_ni,
  input  wire logic                   load_i,        // Capture byte, index to 8
  input  wire logic [`I3C_BYTE_W-1:0] data_i,
  input  wire logic                   bit_next_i,    // Step to next lower bit
  input  wire logic                   sample_ack_i,  // Register SDA for ACK
  input  wire logic                   sda_i,
  output logic                        tx_bit_o,
  output logic                        last_bit_o,
  output logic                        ack_sampled_o  // 0: ACK, 1: NACK
);

  localparam logic [`I3C_BIT_CNT_W-1:0] IdxFirst = (`I3C_BIT_CNT_W)'(8);
  localparam logic [`I3C_BIT_CNT_W-1:0] IdxOne   = (`I3C_BIT_CNT_W)'(1);

  logic [`I3C_BYTE_W-1:0]   data_q;   // Payload, no reset
  logic [`I3C_BIT_CNT_W-1:0] bit_idx_q;
  logic                      ack_q;

  always_ff @(posedge clk_i) begin
    if (load_i) data_q <= data_i;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bit_idx_q <= IdxFirst;
      ack_q     <= 1'b1;                 // Released line reads as NACK
    end else begin
      if (load_i) begin
        bit_idx_q <= IdxFirst;
      end else if (bit_next_i) begin
        bit_idx_q <= bit_idx_q - IdxOne;
      end
      if (sample_ack_i) ack_q <= sda_i;
    end
  end

  // Index 8..1 maps to byte bit 7..0
  assign tx_bit_o      = data_q[3'(bit_idx_q - IdxOne)];
  assign last_bit_o    = (bit_idx_q == IdxOne);
  assign ack_sampled_o = ack_q;

endmodule

`default_nettype wire

// File: design/i3c_ctrl_fsm.sv
// Bus FSM: sequences START/Sr, eight data bits, the 9th bit and STOP, and drives SCL/SDA
`timescale 1ns/1ns
`default_nettype none

module i3c_ctrl_fsm (
  input  wire logic                         clk_i,
  input  wire logic                         rst_ni,
  input  wire logic                         host_enable_i,
  input  wire logic                         tx_valid_i,
  input  wire i3c_bus_pkg::tx_cmd_t         tx_cmd_i,
  input  wire logic                         expired_i,     // Timer at 1
  input  wire logic                         tx_bit_i,      // Current data bit
  input  wire logic                         last_bit_i,
  input  wire logic                         ack_sampled_i,
  output logic                              tx_ready_o,
  output i3c_bus_pkg::tx_status_t           tx_status_o,
  output logic                              host_idle_o,
  output logic                              scl_o,         // 1 = released
  output logic                              sda_o,
  output logic                              tmr_load_o,
  output i3c_timing_pkg::tcount_sel_e       tmr_sel_o,
  output logic                              od_mode_o,
  output logic                              ser_load_o,
  output logic                              bit_next_o,
  output logic                              sample_ack_o
);

  typedef enum logic [4:0] {
    Idle, SetupStart, HoldStart, ClockStart,
    SetupSr, HoldSr, FallSr, ClockSr,
    ClockLow, ClockPulse, HoldBit,
    AckLow, AckPulse, AckHold,
    SetupStop, RiseStop, HoldStop
  } state_e;

  state_e state_q, state_d;
  logic   stop_q, is_addr_q, use_tbit_q;  // Flags kept for the whole byte
  logic   accept;                         // Command taken this cycle
  logic   adv;                            // Interval done, timer running

  assign accept = (state_q == Idle) && tx_valid_i && host_enable_i;
  assign adv    = expired_i && host_enable_i;

  // Address bytes run fully on OD timing, incl. the load made at acceptance
  assign od_mode_o = (state_q == Idle) ? tx_cmd_i.is_addr : is_addr_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      stop_q     <= 1'b0;
      is_addr_q  <= 1'b0;
      use_tbit_q <= 1'b0;
    end else if (accept) begin
      stop_q     <= tx_cmd_i.stop;
      is_addr_q  <= tx_cmd_i.is_addr;
      use_tbit_q <= tx_cmd_i.use_tbit;
    end
  end

  // ==========================================================================
  // Bus levels and status per state
  // ==========================================================================
  always_comb begin
    scl_o       = 1'b1;
    sda_o       = 1'b1;
    tx_ready_o  = 1'b0;
    host_idle_o = 1'b0;
    tx_status_o = '0;
    case (state_q)
      Idle: begin
        host_idle_o = 1'b1;
        tx_ready_o  = host_enable_i;
      end
      HoldStart, FallSr, RiseStop: sda_o = 1'b0;   // SCL high, SDA low
      ClockStart, ClockSr, SetupStop: begin
        scl_o = 1'b0;
        sda_o = 1'b0;
      end
      SetupSr:    scl_o = 1'b0;                     // Release SDA ahead of Sr
      ClockLow, HoldBit: begin
        scl_o = 1'b0;
        sda_o = tx_bit_i;
      end
      ClockPulse: sda_o = tx_bit_i;
      AckLow, AckPulse: begin
        scl_o = (state_q == AckPulse);
        sda_o = is_addr_q || !use_tbit_q;           // T-bit driven low
      end
      AckHold: begin
        scl_o = 1'b0;
        sda_o = 1'b0;
        tx_status_o.done = 1'b1;
        tx_status_o.ack  = is_addr_q && !ack_sampled_i;
        tx_status_o.nack = is_addr_q && ack_sampled_i;
      end
      default: ;                                    // SetupStart, HoldSr, HoldStop
    endcase
  end

  // ==========================================================================
  // Transitions and strobes
  // ==========================================================================
  always_comb begin
    state_d      = state_q;
    tmr_load_o   = 1'b0;
    tmr_sel_o    = i3c_timing_pkg::NoDelay;
    ser_load_o   = 1'b0;
    bit_next_o   = 1'b0;
    sample_ack_o = 1'b0;
    case (state_q)
      Idle: if (accept) begin
        ser_load_o = 1'b1;
        tmr_load_o = 1'b1;
        if (tx_cmd_i.start) begin
          state_d   = SetupStart;
          tmr_sel_o = i3c_timing_pkg::SetupStart;
        end else if (tx_cmd_i.sr) begin
          state_d   = SetupSr;
          tmr_sel_o = i3c_timing_pkg::SetupData;
        end else begin
          state_d   = ClockLow;
          tmr_sel_o = i3c_timing_pkg::ClockLow;
        end
      end
      default: if (adv) begin
        tmr_load_o = 1'b1;
        case (state_q)
          SetupStart: begin state_d = HoldStart;  tmr_sel_o = i3c_timing_pkg::HoldStart;  end
          HoldStart:  begin state_d = ClockStart; tmr_sel_o = i3c_timing_pkg::HoldBit;    end
          SetupSr:    begin state_d = HoldSr;     tmr_sel_o = i3c_timing_pkg::SetupStart; end
          HoldSr:     begin state_d = FallSr;     tmr_sel_o = i3c_timing_pkg::HoldStart;  end
          FallSr:     begin state_d = ClockSr;    tmr_sel_o = i3c_timing_pkg::HoldBit;    end
          ClockLow:   begin state_d = ClockPulse; tmr_sel_o = i3c_timing_pkg::ClockPulse; end
          ClockPulse: begin state_d = HoldBit;    tmr_sel_o = i3c_timing_pkg::HoldBit;    end
          AckLow:     begin state_d = AckPulse;   tmr_sel_o = i3c_timing_pkg::ClockPulse; end
          SetupStop:  begin state_d = RiseStop;   tmr_sel_o = i3c_timing_pkg::SetupStop;  end
          RiseStop:   begin state_d = HoldStop;   tmr_sel_o = i3c_timing_pkg::HoldStop;   end
          HoldStop:   state_d = Idle;
          HoldBit: begin
            state_d    = last_bit_i ? AckLow : ClockLow;
            bit_next_o = !last_bit_i;               // Index moves as ClockLow starts
            tmr_sel_o  = i3c_timing_pkg::ClockLow;
          end
          AckPulse: begin
            state_d      = AckHold;
            tmr_sel_o    = i3c_timing_pkg::HoldBit;
            sample_ack_o = is_addr_q;               // Sampled at SCL fall
          end
          AckHold: begin
            state_d   = stop_q ? SetupStop : Idle;
            tmr_sel_o = stop_q ? i3c_timing_pkg::ClockLow : i3c_timing_pkg::NoDelay;
          end
          default: begin                            // ClockStart, ClockSr
            state_d   = ClockLow;
            tmr_sel_o = i3c_timing_pkg::ClockLow;
          end
        endcase
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) state_q <= Idle;
    else         state_q <= state_d;
  end

endmodule

`default_nettype wire

// File: design/i3c_ctrl_top.sv
// Controller top level that connects the bus FSM, the SCL timer and the byte serializer
`timescale 1ns/1ns
`default_nettype none
`include "i3c_ctrl_params.svh"

module i3c_ctrl_top (
  input  wire logic                         clk_i,
  input  wire logic                         rst_ni,
  input  wire logic                         host_enable_i,
  input  wire i3c_bus_pkg::sys_clk_freq_e   sys_clk_freq_i,
  input  wire i3c_bus_pkg::i3c_trans_mode_e mode_i,
  input  wire i3c_timing_pkg::od_timing_t   od_timing_i,
  input  wire logic                         tx_valid_i,
  input  wire i3c_bus_pkg::tx_cmd_t         tx_cmd_i,
  output logic                              tx_ready_o,
  output i3c_bus_pkg::tx_status_t           tx_status_o,
  output logic                              host_idle_o,
  input  wire logic                         ctrl_scl_i,
  input  wire logic                         ctrl_sda_i,
  output logic                              ctrl_scl_o,
  output logic                              ctrl_sda_o
);
  import i3c_timing_pkg::*;

  // FSM <-> timer
  logic        tmr_load, tmr_expired, od_mode;
  tcount_sel_e tmr_sel;
  // FSM <-> serializer
  logic        ser_load, bit_next, sample_ack;
  logic        tx_bit, last_bit, ack_sampled;

  i3c_ctrl_fsm u_fsm (
    .clk_i, .rst_ni, .host_enable_i, .tx_valid_i, .tx_cmd_i,
    .expired_i    (tmr_expired),
    .tx_bit_i     (tx_bit),
    .last_bit_i   (last_bit),
    .ack_sampled_i(ack_sampled),
    .tx_ready_o, .tx_status_o, .host_idle_o,
    .scl_o        (ctrl_scl_o),
    .sda_o        (ctrl_sda_o),
    .tmr_load_o   (tmr_load),
    .tmr_sel_o    (tmr_sel),
    .od_mode_o    (od_mode),
    .ser_load_o   (ser_load),
    .bit_next_o   (bit_next),
    .sample_ack_o (sample_ack)
  );

  scl_timer u_timer (
    .clk_i, .rst_ni, .host_enable_i, .sys_clk_freq_i, .mode_i, .od_timing_i,
    .load_i   (tmr_load),
    .sel_i    (tmr_sel),
    .od_mode_i(od_mode),
    .expired_o(tmr_expired)
  );

  byte_serializer u_ser (
    .clk_i, .rst_ni,
    .load_i       (ser_load),
    .data_i       (tx_cmd_i.data),
    .bit_next_i   (bit_next),
    .sample_ack_i (sample_ack),
    .sda_i        (ctrl_sda_i),
    .tx_bit_o     (tx_bit),
    .last_bit_o   (last_bit),
    .ack_sampled_o(ack_sampled)
  );

endmodule

`default_nettype wire

// File: dv/i3c_ctrl_chk.sv
// Status and handshake assertions bound into each i3c_ctrl_top instance
`timescale 1ns/1ns
`default_nettype none

module i3c_ctrl_chk (
  input wire logic                   clk_i,
  input wire logic                   rst_ni,
  input wire i3c_bus_pkg::tx_status_t status_i,
  input wire logic                   ready_i,
  input wire logic                   idle_i
);

  logic err_seen = 1'b0;  // Sticky flag set by any failed assertion

  // ACK and NACK never reported together
  ack_nack_excl: assert property (@(posedge clk_i) disable iff (!rst_ni)
    status_i.done |-> !(status_i.ack && status_i.nack))
    else begin
      $error("ack and nack high together with done");
      err_seen = 1'b1;
    end

  // Busy engine never offers to take a command
  ready_when_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !idle_i |-> !ready_i)
    else begin
      $error("tx_ready_o high while not idle");
      err_seen = 1'b1;
    end

  ack_only_with_done: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !status_i.done |-> !(status_i.ack || status_i.nack))
    else begin
      $error("ack or nack high without done");
      err_seen = 1'b1;
    end

endmodule

bind i3c_ctrl_top i3c_ctrl_chk u_chk (
  .clk_i   (clk_i),
  .rst_ni  (rst_ni),
  .status_i(tx_status_o),
  .ready_i (tx_ready_o),
  .idle_i  (host_idle_o)
);

`default_nettype wire

// File: dv/i3c_ctrl_tb.sv
// Testbench for the I3C/I2C TX engine with random commands, a bus target model and protocol checks
`timescale 1ns/1ns
`default_nettype none
`include "i3c_ctrl_params.svh"

module i3c_ctrl_tb;
  import i3c_bus_pkg::*;
  import i3c_timing_pkg::*;

  localparam int unsigned num_cmds     = 48;
  localparam int unsigned byte_timeout = 5000;  // Cycles per byte against a worst PP byte near 1000
  localparam int unsigned accept_limit = 64;

  logic            clk_i;
  logic            rst_ni;
  logic            host_enable_i;
  sys_clk_freq_e   sys_clk_freq_i;
  i3c_trans_mode_e mode_i;
  od_timing_t      od_timing_i;
  logic            tx_valid_i;
  tx_cmd_t         tx_cmd_i;
  logic            tx_ready_o;
  tx_status_t      tx_status_o;
  logic            host_idle_o;
  logic            ctrl_scl_i;
  logic            ctrl_sda_i;
  logic            ctrl_scl_o;
  logic            ctrl_sda_o;
  logic            tgt_pull;    // Target holds SDA low for ACK
  logic [31:0]     rng_state;

  i3c_ctrl_top i3c_ctrl_top_i (.*);

  // Wired-AND bus without clock stretching
  assign ctrl_scl_i = ctrl_scl_o;
  assign ctrl_sda_i = ctrl_sda_o && !tgt_pull;

  always #4 clk_i = ~clk_i;  // 8 ns period

  // ==========================================================================
  // Helpers
  // ==========================================================================
  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift(rng_state);
    return rng_state;
  endfunction

  function automatic logic [`I3C_TIMER_W-1:0] to_tval(input logic [31:0] v);
    return v[`I3C_TIMER_W-1:0];
  endfunction

  // PP half-period in cycles with one row per system clock and SDR0..SDR4 columns
  function automatic int unsigned pp_half(input logic [1:0] freq, input logic [2:0] mode);
    logic [39:0] row;
    logic [2:0]  col;
    case (freq)
      2'd1:    row = {8'd38, 8'd19, 8'd13, 8'd10, 8'd6};
      2'd2:    row = {8'd50, 8'd25, 8'd17, 8'd13, 8'd8};
      default: row = {8'd25, 8'd13, 8'd9, 8'd7, 8'd4};  // 100 MHz row also for unknown clocks
    endcase
    col = (mode > 3'd4) ? 3'd4 : mode;                    // Unknown mode as SDR4
    return 32'(row[col*8 +: 8]);
  endfunction

  task automatic report_mismatch(input string sig, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("FAIL %s: got 0x%0h, expected 0x%0h", sig, got, exp);
    $display("Done: errors found");
    $fatal(1, "stopped at first error");
  endtask

  task automatic report_failure(input string what);
    $display("Error: %s", what);
    $display("Done: errors found");
    $fatal(1, "stopped at first error");
  endtask

  // Watch the sticky flag of the bound checker
  always @(negedge clk_i) begin
    assert (!i3c_ctrl_top_i.u_chk.err_seen)
      else report_failure("a bound bus or status assertion failed");
  end

  // Present a command with the engine optionally disabled for a few cycles
  task automatic send_cmd(input tx_cmd_t cmd, input int unsigned hold);
    int unsigned n;
    logic        acc;
    acc = 1'b0;
    n   = 0;
    tx_cmd_i      = cmd;
    tx_valid_i    = 1'b1;
    host_enable_i = (hold == 0);
    while (!acc) begin
      @(negedge clk_i);
      assert (host_idle_o) else report_failure("engine left idle before acceptance");
      assert (tx_ready_o == host_enable_i)
        else report_mismatch("tx_ready_o", 32'(tx_ready_o), 32'(host_enable_i));
      acc = tx_ready_o;                  // Taken at the coming rising edge
      @(posedge clk_i);
      #1;
      n++;
      if (n >= hold) host_enable_i = 1'b1;
      assert (n < accept_limit) else report_failure("command was never accepted");
    end
    tx_valid_i = 1'b0;
  endtask

  // Follow one byte from acceptance back to Idle and check bus and status
  task automatic run_byte(input tx_cmd_t cmd, input logic ack_choice,
                          input int unsigned t_high);
    int unsigned cyc;
    int unsigned rises;                  // Data and 9th-bit rising edges
    int unsigned hi_cnt;
    logic        scl_p, sda_p, scl, sda;
    logic        framed, sr_rise, in_bit, done_seen, done_p, stop_seen;
    logic [8:0]  exp_bits;
    cyc       = 0;
    rises     = 0;
    hi_cnt    = 0;
    scl_p     = 1'b1;                    // Idle levels before acceptance
    sda_p     = 1'b1;
    framed    = !(cmd.start || cmd.sr);
    sr_rise   = 1'b0;
    in_bit    = 1'b0;
    done_seen = 1'b0;
    done_p    = 1'b0;
    stop_seen = 1'b0;
    exp_bits  = {cmd.data, !(cmd.use_tbit && !cmd.is_addr)};  // T-bit data bytes pull it low
    while (!host_idle_o) begin
      scl = ctrl_scl_o;
      sda = ctrl_sda_o;
      assert (!tx_ready_o) else report_mismatch("tx_ready_o", 32'(tx_ready_o), 32'(0));
      if (scl_p && scl && sda_p && !sda && (cmd.start || sr_rise)) framed = 1'b1;
      if (scl_p && scl && !sda_p && sda && done_seen) stop_seen = 1'b1;
      if (!scl_p && scl && !done_seen) begin
        if (cmd.sr && !cmd.start && !sr_rise) begin
          assert (sda) else report_mismatch("ctrl_sda_o", 32'(sda), 32'(1));  // Sr released
          sr_rise = 1'b1;
        end else begin
          assert (framed) else report_failure("no START or Sr before the first data bit");
          assert (rises < 9) else report_failure("more than nine SCL pulses in one byte");
          assert (sda == exp_bits[8-rises])
            else report_mismatch("ctrl_sda_o", 32'(sda), 32'(exp_bits[8-rises]));
          rises++;
          in_bit = 1'b1;
          hi_cnt = 0;
        end
      end
      if (scl && in_bit) hi_cnt++;
      if (scl_p && !scl && in_bit) begin
        assert (hi_cnt == t_high) else report_mismatch("scl high cycles", hi_cnt, t_high);
        in_bit = 1'b0;
        if (rises == 8) tgt_pull = cmd.is_addr && ack_choice;  // Drive the 9th bit
        if (rises == 9) tgt_pull = 1'b0;
      end
      if (tx_status_o.done && !done_p) begin
        assert (rises == 9) else report_failure("done rose before the 9th clock ended");
        if (cmd.is_addr) begin
          assert (tx_status_o.ack == ack_choice)
            else report_mismatch("tx_status_o.ack", 32'(tx_status_o.ack), 32'(ack_choice));
          assert (tx_status_o.nack == !ack_choice)
            else report_mismatch("tx_status_o.nack", 32'(tx_status_o.nack), 32'(!ack_choice));
        end else begin
          assert (!tx_status_o.ack && !tx_status_o.nack)
            else report_mismatch("tx_status_o", 32'(tx_status_o), 32'(3'b100));
        end
        done_seen = 1'b1;
      end
      done_p = tx_status_o.done;
      scl_p  = scl;
      sda_p  = sda;
      cyc++;
      assert (cyc < byte_timeout) else report_failure("byte transfer did not finish in time");
      @(posedge clk_i);
      #1;
    end
    assert (done_seen) else report_failure("engine returned to idle without done");
    assert (stop_seen == cmd.stop)
      else report_mismatch("stop condition", 32'(stop_seen), 32'(cmd.stop));
    tgt_pull = 1'b0;
  endtask

  // ==========================================================================
  // Stimulus
  // ==========================================================================
  initial begin
    tx_cmd_t     cmd;
    od_timing_t  od;
    logic [31:0] r;
    logic [31:0] t;
    logic [1:0]  frame;
    int unsigned exp_high;
    int          k;
    rng_state      = 32'd42;
    clk_i          = 1'b0;
    rst_ni         = 1'b0;
    host_enable_i  = 1'b1;
    sys_clk_freq_i = SysClk100MHz;
    mode_i         = Sdr0;
    od_timing_i    = '0;
    tx_valid_i     = 1'b0;
    tx_cmd_i       = '0;
    tgt_pull       = 1'b0;
    repeat (10) @(posedge clk_i);
    #1 rst_ni = 1'b1;
    @(posedge clk_i);
    #1;
    assert (ctrl_scl_o && ctrl_sda_o) else report_failure("bus lines not released after reset");
    assert (tx_status_o == '0) else report_mismatch("tx_status_o", 32'(tx_status_o), 32'(0));
    assert (host_idle_o) else report_mismatch("host_idle_o", 32'(host_idle_o), 32'(1));
    assert (tx_ready_o) else report_mismatch("tx_ready_o", 32'(tx_ready_o), 32'(1));

    for (k = 0; k < num_cmds; k++) begin
      r     = next_rand();
      t     = next_rand();
      frame = r[1:0] % 2'd3;                 // None, START or Sr
      cmd.start    = (frame == 2'd1);
      cmd.sr       = (frame == 2'd2);
      cmd.stop     = r[2];
      cmd.is_addr  = r[3];
      cmd.use_tbit = r[4];
      cmd.data     = r[15:8];
      // Small OD values that keep ClockLow and HoldStop intervals above zero
      od.thigh   = to_tval(1 + t[2:0]);
      od.t_r     = to_tval(1 + t[4:3]);
      od.t_f     = to_tval(1 + t[6:5]);
      od.thd_dat = to_tval(1 + t[8:7]);
      od.tlow    = od.thd_dat + to_tval(1 + t[11:9]);
      od.thd_sta = to_tval(1 + t[13:12]);
      od.tsu_sta = to_tval(1 + t[15:14]);
      od.tsu_sto = to_tval(1 + t[17:16]);
      od.tsu_dat = to_tval(1 + t[19:18]);
      od.t_buf   = od.tsu_sta + to_tval(32'(t[21:20]));
      od_timing_i    = od;
      sys_clk_freq_i = sys_clk_freq_e'(r[21:20]);
      mode_i         = i3c_trans_mode_e'(r[24:22]);
      exp_high = cmd.is_addr ? (32'(od.t_r) + 32'(od.thigh)) : pp_half(r[21:20], r[24:22]);
      send_cmd(cmd, r[26] ? 0 : 32'(r[28:27]));
      run_byte(cmd, r[5], exp_high);
    end

    if (i3c_ctrl_top_i.u_chk.err_seen) begin
      report_failure("a bound bus or status assertion failed");
    end else begin
      $display("Done: no errors");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+common
common/i3c_bus_pkg.sv
common/i3c_timing_pkg.sv
timing/scl_timer.sv
design/byte_serializer.sv
design/i3c_ctrl_fsm.sv
design/i3c_ctrl_top.sv
dv/i3c_ctrl_chk.sv
dv/i3c_ctrl_tb.sv
